// File: vlog.f
verilog/xlat_pkg.sv
verilog/command_scaler.sv
verilog/burst_sequencer.sv
verilog/beat_tracker.sv
verilog/master_translator.sv
dv/master_translator_checker.sv
dv/tb_master_translator.sv

// File: dv/tb_master_translator.sv
`default_nettype none

module tb_master_translator
   import xlat_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int          CLK_PERIOD = 100;
   localparam logic [15:0] LFSR_SEED  = 16'd28650;
   localparam logic [15:0] LFSR_TAPS  = 16'hB400;
   localparam int          MEM_BYTES  = 256;
   localparam int          MAX_LEN    = 15;
   localparam int          N_BURSTS   = 8;
   localparam int          N_BE_TESTS = 4;

   // writes and read words of every test, upper bound
   localparam int TOTAL_BEATS = 2 + N_BURSTS * 2 * MAX_LEN + N_BE_TESTS * 3 + 3 + 2 * MAX_LEN;
   localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40 + 200;

   typedef struct packed {
      logic [UAV_ADDR_W-1:0]  addr;
      logic [UAV_BURST_W-1:0] count;
   } beat_ref_t;

   logic     clk;
   logic     reset;
   av_cmd_t  av_cmd;
   logic     av_waitrequest;
   rsp_t     av_rsp;
   uav_cmd_t uav_cmd;
   logic     uav_waitrequest;
   rsp_t     uav_rsp;

   logic [15:0]          lfsr_state;
   logic [7:0]           mem [MEM_BYTES];
   logic [7:0]           shadow [MEM_BYTES];
   logic [AV_DATA_W-1:0] exp_rd_q [$];

   // beat on offer, published by the stimulus for the compare process
   string                test_name = "idle";
   logic [AV_ADDR_W-1:0] cur_a = '0;
   int                   cur_n = 0;
   int                   cur_idx = 0;
   logic [AV_BE_W-1:0]   cur_be = '0;
   logic [AV_DATA_W-1:0] cur_data = '0;

   int cmd_errors = 0;
   int rsp_errors = 0;
   int proto_errors = 0;
   int planned_wr_beats = 0;
   int planned_reads = 0;
   int planned_rd_words = 0;
   int wr_beats_seen = 0;
   int rd_cmds_seen = 0;
   int rd_words_seen = 0;

   master_translator u_dut (
      .clk             (clk),
      .reset           (reset),
      .av_cmd          (av_cmd),
      .av_waitrequest  (av_waitrequest),
      .av_rsp          (av_rsp),
      .uav_cmd         (uav_cmd),
      .uav_waitrequest (uav_waitrequest),
      .uav_rsp         (uav_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ LFSR_TAPS;
      end
      return s >> 1;
   endfunction

   // one LFSR step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          k;
      v = '0;
      for (k = 0; k < n; k++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic logic [7:0] fill_byte(input int i);
      return 8'(i * 29 + 165);
   endfunction

   // expected downstream address and byte count of beat i
   function automatic beat_ref_t ref_beat(input logic [AV_ADDR_W-1:0] a, input int n,
                                          input int i);
      beat_ref_t r;
      r.addr  = UAV_ADDR_W'(a) * UAV_ADDR_W'(SYMBOLS_PER_WORD)
              + UAV_ADDR_W'(i * SYMBOLS_PER_WORD);
      r.count = UAV_BURST_W'((n - i) * SYMBOLS_PER_WORD);
      return r;
   endfunction

   // next rising edge, with a fresh stall decision for the slave
   task automatic tick();
      @(posedge clk);
      uav_waitrequest <= (rand_bits(2) == 2'b11);
   endtask

   // returns at the falling edge before the edge that accepts the beat
   task automatic wait_accept();
      @(negedge clk);
      while (av_waitrequest) begin
         tick();
         @(negedge clk);
      end
   endtask

   task automatic write_burst(input string name, input logic [AV_ADDR_W-1:0] a,
                              input int n, input int beats, input bit partial);
      av_cmd_t    c;
      beat_ref_t  r;
      logic [7:0] idx;
      int         i;
      int         b;
      for (i = 0; i < beats; i++) begin
         tick();
         c            = '0;
         c.write      = 1'b1;
         c.address    = a;
         c.burstcount = AV_BURST_W'(n);
         c.byteenable = {AV_BE_W{1'b1}};
         if (partial) begin
            c.byteenable = AV_BE_W'(rand_bits(AV_BE_W));
            if (c.byteenable == '0) begin
               c.byteenable = 4'b0101;
            end
         end
         c.writedata = rand_bits(AV_DATA_W);
         test_name   = name;
         cur_a       = a;
         cur_n       = n;
         cur_idx     = i;
         cur_be      = c.byteenable;
         cur_data    = c.writedata;
         av_cmd <= c;
         wait_accept();
         r = ref_beat(a, n, i);
         for (b = 0; b < AV_BE_W; b++) begin
            idx = r.addr[7:0] + 8'(b);
            if (c.byteenable[b]) begin
               shadow[idx] = c.writedata[8*b +: 8];
            end
         end
         planned_wr_beats++;
      end
      tick();
      av_cmd <= '0;
   endtask

   task automatic read_burst(input string name, input logic [AV_ADDR_W-1:0] a, input int n);
      av_cmd_t              c;
      beat_ref_t            r;
      logic [7:0]           idx;
      logic [AV_DATA_W-1:0] w;
      int                   k;
      int                   b;
      tick();
      c            = '0;
      c.read       = 1'b1;
      c.address    = a;
      c.burstcount = AV_BURST_W'(n);
      c.byteenable = {AV_BE_W{1'b1}};
      test_name    = name;
      cur_a        = a;
      cur_n        = n;
      cur_idx      = 0;
      cur_be       = c.byteenable;
      cur_data     = '0;
      // word k of the read sits where beat k of a burst would write
      for (k = 0; k < n; k++) begin
         r = ref_beat(a, n, k);
         for (b = 0; b < AV_BE_W; b++) begin
            idx = r.addr[7:0] + 8'(b);
            w[8*b +: 8] = shadow[idx];
         end
         exp_rd_q.push_back(w);
      end
      av_cmd <= c;
      wait_accept();
      tick();
      av_cmd <= '0;
      planned_reads++;
      planned_rd_words += n;
      while (exp_rd_q.size() != 0) begin
         tick();
      end
   endtask

   task automatic finish_run();
      int total;
      total = cmd_errors + rsp_errors + proto_errors + int'(u_dut.u_checker.assert_fails);
      $display("errors: command %0d, read data %0d, protocol %0d, assertions %0d",
               cmd_errors, rsp_errors, proto_errors, u_dut.u_checker.assert_fails);
      if (total == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   endtask

   // ------------------------------------------------------------
   // slave model, byte-addressed memory
   // ------------------------------------------------------------

   initial begin : slave_model
      rsp_t                 rsp;
      logic [7:0]           idx;
      logic [AV_DATA_W-1:0] word;
      logic [AV_DATA_W-1:0] rd_q [$];
      int                   rd_wait;
      int                   words;
      int                   k;
      int                   b;
      uav_rsp = '0;
      rd_wait = 0;
      for (k = 0; k < MEM_BYTES; k++) begin
         mem[k] = fill_byte(k);
      end
      forever begin
         @(posedge clk);
         // first read word goes out two edges after the accepting edge
         rsp = '0;
         if (rd_wait > 0) begin
            rd_wait--;
         end else if (rd_q.size() != 0) begin
            rsp.readdata      = rd_q.pop_front();
            rsp.readdatavalid = 1'b1;
         end
         uav_rsp <= rsp;
         if (!uav_waitrequest && uav_cmd.write) begin
            for (b = 0; b < AV_BE_W; b++) begin
               idx = uav_cmd.address[7:0] + 8'(b);
               if (uav_cmd.byteenable[b]) begin
                  mem[idx] = uav_cmd.writedata[8*b +: 8];
               end
            end
         end
         if (!uav_waitrequest && uav_cmd.read) begin
            words = int'(uav_cmd.burstcount) / SYMBOLS_PER_WORD;
            for (k = 0; k < words; k++) begin
               for (b = 0; b < AV_BE_W; b++) begin
                  idx = uav_cmd.address[7:0] + 8'(SYMBOLS_PER_WORD * k + b);
                  word[8*b +: 8] = mem[idx];
               end
               rd_q.push_back(word);
            end
            rd_wait = 1;
         end
      end
   end

   // ------------------------------------------------------------
   // comparison, mid-cycle when all outputs have settled
   // ------------------------------------------------------------

   always @(negedge clk) begin : compare_beats
      beat_ref_t            r;
      logic [AV_DATA_W-1:0] exp_word;
      assert (av_waitrequest == uav_waitrequest) else begin
         proto_errors++;
         $display("FAILED %s waitrequest: expected %b, actual %b",
                  test_name, uav_waitrequest, av_waitrequest);
      end
      if (!reset && (uav_cmd.write || uav_cmd.read)) begin
         r = ref_beat(cur_a, cur_n, cur_idx);
         assert (uav_cmd.address == r.addr) else begin
            cmd_errors++;
            $display("FAILED %s beat %0d address: expected %h, actual %h",
                     test_name, cur_idx, r.addr, uav_cmd.address);
         end
         assert (uav_cmd.burstcount == r.count) else begin
            cmd_errors++;
            $display("FAILED %s beat %0d count: expected %0d, actual %0d",
                     test_name, cur_idx, r.count, uav_cmd.burstcount);
         end
         if (uav_cmd.write) begin
            assert ({uav_cmd.byteenable, uav_cmd.writedata} == {cur_be, cur_data}) else begin
               cmd_errors++;
               $display("FAILED %s beat %0d be/data: expected %h/%h, actual %h/%h",
                        test_name, cur_idx, cur_be, cur_data,
                        uav_cmd.byteenable, uav_cmd.writedata);
            end
         end
         if (!uav_waitrequest && uav_cmd.write) begin
            wr_beats_seen++;
         end
         if (!uav_waitrequest && uav_cmd.read) begin
            rd_cmds_seen++;
         end
      end
      if (av_rsp.readdatavalid) begin
         assert (exp_rd_q.size() != 0) else begin
            proto_errors++;
            $display("read data came back while no read was outstanding");
         end
         if (exp_rd_q.size() != 0) begin
            exp_word = exp_rd_q.pop_front();
            rd_words_seen++;
            assert (av_rsp.readdata == exp_word) else begin
               rsp_errors++;
               $display("FAILED %s readdata: expected %h, actual %h",
                        test_name, exp_word, av_rsp.readdata);
            end
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      proto_errors++;
      $display("timeout: the run was still busy after %0d clock periods", WATCHDOG_CYCLES);
      finish_run();
   end

   // ------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------

   initial begin : stimulus
      logic [AV_ADDR_W-1:0] a;
      int                   n;
      int                   k;
      lfsr_state      = LFSR_SEED;
      reset           = 1'b1;
      av_cmd          = '0;
      uav_waitrequest = 1'b0;
      for (k = 0; k < MEM_BYTES; k++) begin
         shadow[k] = fill_byte(k);
      end
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      repeat (2) tick();

      a = rand_bits(AV_ADDR_W);
      write_burst("single_write", a, 1, 1, 1'b0);
      read_burst("single_read", a, 1);

      // random lengths under random back-pressure, each read back
      repeat (N_BURSTS) begin
         a = rand_bits(AV_ADDR_W);
         n = int'(rand_bits(AV_BURST_W));
         if (n == 0) begin
            n = MAX_LEN;
         end
         write_burst("write_burst", a, n, n, 1'b0);
         read_burst("read_burst", a, n);
      end

      repeat (N_BE_TESTS) begin
         a = rand_bits(AV_ADDR_W);
         write_burst("byte_enable_full", a, 1, 1, 1'b0);
         write_burst("byte_enable_partial", a, 1, 1, 1'b1);
         read_burst("byte_enable_read", a, 1);
      end

      // reset while a write burst is still open
      a = rand_bits(AV_ADDR_W);
      write_burst("reset_abort", a, 8, 3, 1'b0);
      tick();
      reset <= 1'b1;
      repeat (2) tick();
      reset <= 1'b0;
      a = rand_bits(AV_ADDR_W);
      n = int'(rand_bits(AV_BURST_W)) | 2;
      write_burst("reset_restart", a, n, n, 1'b0);
      read_burst("reset_read", a, n);
      repeat (4) tick();

      assert (wr_beats_seen == planned_wr_beats) else begin
         cmd_errors++;
         $display("FAILED write_beat_count: expected %0d, actual %0d",
                  planned_wr_beats, wr_beats_seen);
      end
      assert (rd_cmds_seen == planned_reads) else begin
         cmd_errors++;
         $display("FAILED read_cmd_count: expected %0d, actual %0d", planned_reads, rd_cmds_seen);
      end
      assert (rd_words_seen == planned_rd_words) else begin
         rsp_errors++;
         $display("FAILED read_word_count: expected %0d, actual %0d",
                  planned_rd_words, rd_words_seen);
      end
      finish_run();
   end

endmodule

`default_nettype wire

// File: dv/master_translator_checker.sv
`default_nettype none

// handshake checks on the translator ports, bound into master_translator

module master_translator_checker
   import xlat_pkg::*;
(
   input logic     clk,
   input logic     reset,
   input av_cmd_t  av_cmd,
   input logic     av_waitrequest,
   input uav_cmd_t uav_cmd,
   input logic     uav_waitrequest
);

   timeunit 1ns;
   timeprecision 100ps;

   // failed assertions so far, the testbench adds these to its totals
   int unsigned assert_fails = 0;

   // ----------------------------------------------------------
   // upstream hold under back-pressure
   // ----------------------------------------------------------

   property cmd_held_while_stalled;
      @(posedge clk) disable iff (reset)
         (av_waitrequest && (av_cmd.write || av_cmd.read)) |=> $stable(av_cmd);
   endproperty

   a_cmd_held : assert property (cmd_held_while_stalled)
      else begin
         assert_fails++;
         $error("av_cmd changed while av_waitrequest was high");
      end

   // a stalled beat must be offered again with the same values
   property beat_repeats_while_stalled;
      @(posedge clk) disable iff (reset)
         (uav_waitrequest && (uav_cmd.write || uav_cmd.read)) |=> $stable(uav_cmd);
   endproperty

   a_beat_repeats : assert property (beat_repeats_while_stalled)
      else begin
         assert_fails++;
         $error("uav_cmd changed while uav_waitrequest was high");
      end

   // ----------------------------------------------------------
   // downstream write length
   // ----------------------------------------------------------

   a_write_count : assert property (@(posedge clk) disable iff (reset)
         uav_cmd.write |-> (uav_cmd.burstcount != '0))
      else begin
         assert_fails++;
         $error("downstream write offered with a byte count of zero");
      end

endmodule

bind master_translator master_translator_checker u_checker (
   .clk             (clk),
   .reset           (reset),
   .av_cmd          (av_cmd),
   .av_waitrequest  (av_waitrequest),
   .uav_cmd         (uav_cmd),
   .uav_waitrequest (uav_waitrequest)
);

`default_nettype wire

// File: verilog/master_translator.sv
`default_nettype none

// Word-addressed bursting master to byte-addressed fabric.
// Command path runs scaler, sequencer and tracker with no registers
// in between, so uav_cmd follows av_cmd in the same cycle.
// Waitrequest and read responses pass straight through.

module master_translator
   import xlat_pkg::*;
(
   input  logic     clk,
   input  logic     reset,

   // upstream master side
   input  av_cmd_t  av_cmd,
   output logic     av_waitrequest,
   output rsp_t     av_rsp,

   // downstream fabric side
   output uav_cmd_t uav_cmd,
   input  logic     uav_waitrequest,
   input  rsp_t     uav_rsp
);

   // ----------------------------------------------------------
   // internal links
   // ----------------------------------------------------------

   uav_cmd_t scaled_cmd;
   logic     burst_start;
   logic     beat_done;
   logic     last_beat;

   // ----------------------------------------------------------
   // command path
   // ----------------------------------------------------------

   command_scaler u_scaler (
      .cmd_in     (av_cmd),
      .scaled_cmd (scaled_cmd)
   );

   burst_sequencer u_sequencer (
      .clk         (clk),
      .reset       (reset),
      .scaled_cmd  (scaled_cmd),
      .burst_start (burst_start),
      .beat_done   (beat_done),
      .beat_cmd    (uav_cmd),
      .last_beat   (last_beat)
   );

   // tracker looks at the scaled command so the beat select
   // does not feed back into its own decode
   beat_tracker u_tracker (
      .clk         (clk),
      .reset       (reset),
      .cmd         (scaled_cmd),
      .waitrequest (uav_waitrequest),
      .last_beat   (last_beat),
      .burst_start (burst_start),
      .beat_done   (beat_done)
   );

   // ----------------------------------------------------------
   // return path
   // ----------------------------------------------------------

   // back-pressure reaches the master in the same cycle
   assign av_waitrequest = uav_waitrequest;

   // read data and its valid flag are not touched
   assign av_rsp = uav_rsp;

endmodule

`default_nettype wire

// File: verilog/beat_tracker.sv
`default_nettype none

// Decides which beat opens a burst and which beats are accepted.
// A write burst stays open from its first accepted beat until its
// last accepted beat. Reads are always single requests.

module beat_tracker
   import xlat_pkg::*;
(
   input  logic     clk,
   input  logic     reset,

   input  uav_cmd_t cmd,
   input  logic     waitrequest,
   input  logic     last_beat,

   output logic     burst_start,
   output logic     beat_done
);

   // ----------------------------------------------------------
   // open burst flag
   // ----------------------------------------------------------

   // high between the first and the last beat of a write burst
   logic burst_open;
   logic burst_open_next;

   // ----------------------------------------------------------
   // beat decode
   // ----------------------------------------------------------

   // a write beat is taken in any cycle without waitrequest
   assign beat_done = cmd.write & ~waitrequest;

   // reads always begin their own burst, writes only when
   // no earlier write burst is still running
   assign burst_start = cmd.read | (cmd.write & ~burst_open);

   // ----------------------------------------------------------
   // flag update
   // ----------------------------------------------------------

   always_comb begin
      burst_open_next = burst_open;
      if (cmd.read) begin
         burst_open_next = 1'b0;
      end else if (beat_done) begin
         // a single-beat burst never opens
         burst_open_next = ~last_beat;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         burst_open <= 1'b0;
      end else begin
         burst_open <= burst_open_next;
      end
   end

endmodule

`default_nettype wire

// File: verilog/burst_sequencer.sv
`default_nettype none

// Per-beat address and length for write bursts.
// The first beat of a burst uses the scaled command directly. Every
// later beat uses the registers, which step one word forward and one
// word down each time a write beat is accepted.

module burst_sequencer
   import xlat_pkg::*;
(
   input  logic     clk,
   input  logic     reset,

   input  uav_cmd_t scaled_cmd,
   input  logic     burst_start,
   input  logic     beat_done,

   output uav_cmd_t beat_cmd,
   output logic     last_beat
);

   // ----------------------------------------------------------
   // burst state
   // ----------------------------------------------------------

   logic [UAV_ADDR_W-1:0] addr_reg;
   logic [BEAT_LEN_W-1:0] len_reg;

   // length of the incoming command in words
   logic [BEAT_LEN_W-1:0] scaled_len;

   // values that belong to the beat on the bus right now
   logic [UAV_ADDR_W-1:0] cur_addr;
   logic [BEAT_LEN_W-1:0] cur_len;

   // next register values once this beat is taken
   logic [UAV_ADDR_W-1:0] next_addr;
   logic [BEAT_LEN_W-1:0] next_len;

   // drop the symbol bits again to count in words
   assign scaled_len = scaled_cmd.burstcount[UAV_BURST_W-1:BYTE_SEL_W];

   // ----------------------------------------------------------
   // current beat select
   // ----------------------------------------------------------

   always_comb begin
      if (burst_start) begin
         cur_addr = scaled_cmd.address;
         cur_len  = scaled_len;
      end else begin
         cur_addr = addr_reg;
         cur_len  = len_reg;
      end
   end

   // the compare runs on whichever length is live for this beat
   assign last_beat = (cur_len == BEAT_LEN_W'(1));

   assign next_addr = cur_addr + UAV_ADDR_W'(SYMBOLS_PER_WORD);
   assign next_len  = cur_len - BEAT_LEN_W'(1);

   // ----------------------------------------------------------
   // register update
   // ----------------------------------------------------------

   // only an accepted write beat moves the burst forward,
   // a stalled beat keeps both registers as they are
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         addr_reg <= '0;
         len_reg  <= '0;
      end else if (beat_done) begin
         addr_reg <= next_addr;
         len_reg  <= next_len;
      end
   end

   // ----------------------------------------------------------
   // downstream command
   // ----------------------------------------------------------

   always_comb begin
      beat_cmd            = scaled_cmd;
      beat_cmd.address    = cur_addr;
      // remaining words back to bytes
      beat_cmd.burstcount = {cur_len, {BYTE_SEL_W{1'b0}}};
   end

endmodule

`default_nettype wire

// File: verilog/command_scaler.sv
`default_nettype none

// Rescales the upstream command from word units into byte units.
// The address and the burst count both gain BYTE_SEL_W zero bits
// at the bottom, everything else is carried over as is.

module command_scaler
   import xlat_pkg::*;
(
   input  av_cmd_t  cmd_in,
   output uav_cmd_t scaled_cmd
);

   // ----------------------------------------------------------
   // unit conversion
   // ----------------------------------------------------------

   logic [UAV_ADDR_W-1:0]  byte_address;
   logic [UAV_BURST_W-1:0] byte_count;

   // word address to byte address, low bits select byte 0
   always_comb begin
      byte_address = {cmd_in.address, {BYTE_SEL_W{1'b0}}};
   end

   // words to symbols, same shift as the address
   always_comb begin
      byte_count = {cmd_in.burstcount, {BYTE_SEL_W{1'b0}}};
   end

   // ----------------------------------------------------------
   // output command
   // ----------------------------------------------------------

   always_comb begin
      // control bits go straight across
      scaled_cmd.write      = cmd_in.write;
      scaled_cmd.read       = cmd_in.read;

      scaled_cmd.address    = byte_address;
      scaled_cmd.burstcount = byte_count;

      // data lanes are not touched
      scaled_cmd.byteenable = cmd_in.byteenable;
      scaled_cmd.writedata  = cmd_in.writedata;
   end

endmodule

`default_nettype wire

// File: verilog/xlat_pkg.sv
`default_nettype none

package xlat_pkg;

   // ----------------------------------------------------------
   // bus widths
   // ----------------------------------------------------------

   // upstream word-addressed side
   localparam int AV_ADDR_W        = 32;
   localparam int AV_DATA_W        = 32;
   localparam int AV_BURST_W       = 4;
   localparam int AV_BE_W          = AV_DATA_W / 8;

   // bytes in one data word and the address bits that pick one of them
   localparam int SYMBOLS_PER_WORD = 4;
   localparam int BYTE_SEL_W       = 2;

   // downstream byte-addressed side
   localparam int UAV_ADDR_W       = AV_ADDR_W + BYTE_SEL_W;
   localparam int UAV_BURST_W      = AV_BURST_W + BYTE_SEL_W;

   // remaining words in a write burst
   localparam int BEAT_LEN_W       = AV_BURST_W;

   // ----------------------------------------------------------
   // command and response bundles
   // ----------------------------------------------------------

   typedef struct packed {
      logic                  write;
      logic                  read;
      logic [AV_ADDR_W-1:0]  address;
      logic [AV_BURST_W-1:0] burstcount;
      logic [AV_BE_W-1:0]    byteenable;
      logic [AV_DATA_W-1:0]  writedata;
   } av_cmd_t;

   // burstcount is in bytes here
   typedef struct packed {
      logic                   write;
      logic                   read;
      logic [UAV_ADDR_W-1:0]  address;
      logic [UAV_BURST_W-1:0] burstcount;
      logic [AV_BE_W-1:0]     byteenable;
      logic [AV_DATA_W-1:0]   writedata;
   } uav_cmd_t;

   typedef struct packed {
      logic [AV_DATA_W-1:0] readdata;
      logic                 readdatavalid;
   } rsp_t;

endpackage

`default_nettype wire
